//--- memPipeTop.f
design/memPipePkg.sv
design/physRegFile.sv
design/memRegReadStage.sv
design/memExecStage.sv
design/memResultStage.sv
design/memPipeTop.sv
test/memPipeTb.sv

//--- test/memPipeTb.sv
/*
 * Testbench for the memory pipeline slice
 * Stimulus table with LFSR data, reference model and completion checks
 */
`timescale 1ns/1ps

module memPipeTb import memPipePkg::*; ();

    localparam int DRAIN_LIMIT = 12;

    typedef struct packed {
        logic [2:0]                testId;
        logic                      stall;
        FlushReq                   flush;
        logic                      allocValid;
        logic [PREG_NUM_WIDTH-1:0] allocReg;
        MemIssueEntry              issue;
    } StimRow;

    typedef struct packed {
        logic                    replay;
        logic                    isStore;
        logic                    checkData;
        logic [AL_PTR_WIDTH-1:0] activeListPtr;
        logic [DATA_WIDTH-1:0]   addr;
        logic [DATA_WIDTH-1:0]   loadData;
        // Advance count at which the op sits in the result register
        logic [31:0]             due;
    } ExpCompletion;

    logic                      clk;
    logic                      rstN;
    MemIssueEntry              issue;
    logic                      stall;
    FlushReq                   flush;
    logic                      allocValid;
    logic [PREG_NUM_WIDTH-1:0] allocReg;
    MemCompletion              completion;

    StimRow                stimTable[$];
    ExpCompletion          expQ[$];
    logic [DATA_WIDTH-1:0] modelReg [PREG_NUM];
    logic [PREG_NUM-1:0]   modelReady;
    logic [DATA_WIDTH-1:0] modelMem [DMEM_WORDS];
    // Op the model believes sits in the register-read register
    MemIssueEntry            rrOp;
    // Clock edges on which the pipe moved forward
    int                      advanceCount;
    logic [31:0]             lfsrState;
    logic [AL_PTR_WIDTH-1:0] nextAlPtr;
    int                      checkCount;
    int                      errorCount;

    memPipeTop u_dut (
        .clk(clk), .rstN(rstN), .issue(issue), .stall(stall), .flush(flush),
        .allocValid(allocValid), .allocReg(allocReg), .completion(completion)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
        return v;
    endfunction

    function automatic logic [31:0] randomOffset();
        return takeBits(4) << 2;
    endfunction

    // Distance from head modulo the ring size, compared with the range length
    function automatic logic inFlushRange(input logic [AL_PTR_WIDTH-1:0] ptr,
                                          input logic [AL_PTR_WIDTH-1:0] head,
                                          input logic [AL_PTR_WIDTH-1:0] tail);
        logic [AL_PTR_WIDTH-1:0] fromHead;
        logic [AL_PTR_WIDTH-1:0] span;
        fromHead = ptr - head;
        span = tail - head;
        return fromHead < span;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] operandOf(input OpOperandType t,
                                                       input logic [DATA_WIDTH-1:0] regVal,
                                                       input logic [DATA_WIDTH-1:0] immVal,
                                                       input logic [DATA_WIDTH-1:0] pcVal);
        if (t == OOT_IMM) begin
            return immVal;
        end else if (t == OOT_PC) begin
            return pcVal;
        end
        return regVal;
    endfunction

    function automatic string testName(input int t);
        case (t)
            1: return "store then load";
            2: return "operand types";
            3: return "replay on unready source";
            4: return "selective flush";
            5: return "stall with two in flight";
            default: return "back-to-back random ops";
        endcase
    endfunction

    task automatic appendOp(input logic [2:0] t, input logic st,
                            input OpOperandType ta, input logic [4:0] ra,
                            input OpOperandType tb, input logic [4:0] rb,
                            input logic [4:0] dst, input logic [31:0] imm, input logic [31:0] pc);
        StimRow r;
        r = '0;
        r.testId = t;
        r.issue.valid = 1'b1;
        r.issue.isStore = st;
        r.issue.operandTypeA = ta;
        r.issue.phySrcRegNumA = ra;
        r.issue.operandTypeB = tb;
        r.issue.phySrcRegNumB = rb;
        r.issue.writeReg = !st;
        r.issue.phyDstRegNum = dst;
        r.issue.imm = imm;
        r.issue.pc = pc;
        r.issue.activeListPtr = nextAlPtr;
        nextAlPtr++;
        stimTable.push_back(r);
    endtask

    task automatic idleRows(input logic [2:0] t, input logic st, input int n);
        StimRow r;
        r = '0;
        r.testId = t;
        r.stall = st;
        for (int i = 0; i < n; i++) begin
            stimTable.push_back(r);
        end
    endtask

    // Flush hits the op issued one row earlier
    task automatic attachFlush(input logic all, input logic [3:0] head, input logic [3:0] tail);
        StimRow r;
        r = stimTable.pop_back();
        r.flush = {1'b1, all, head, tail};
        stimTable.push_back(r);
    endtask

    task automatic attachAlloc(input logic [4:0] regNum);
        StimRow r;
        r = stimTable.pop_back();
        r.allocValid = 1'b1;
        r.allocReg = regNum;
        stimTable.push_back(r);
    endtask

    task automatic pinAlPtr(input logic [3:0] ptr);
        StimRow r;
        r = stimTable.pop_back();
        r.issue.activeListPtr = ptr;
        stimTable.push_back(r);
    endtask

    task automatic buildTable();
        logic [31:0] o;
        logic [31:0] w;
        logic        st;
        idleRows(1, 1'b0, 2);
        for (int i = 0; i < DMEM_WORDS; i++) begin
            appendOp(1, 1'b1, OOT_REG, 0, OOT_PC, 0, 0, i * 4, takeBits(32));
        end
        o = randomOffset();
        appendOp(1, 1'b1, OOT_REG, 0, OOT_PC, 0, 0, o, takeBits(32));
        appendOp(1, 1'b0, OOT_REG, 0, OOT_REG, 0, 5, o, 0);

        appendOp(2, 1'b1, OOT_PC, 0, OOT_PC, 0, 0, randomOffset(), takeBits(32));
        appendOp(2, 1'b0, OOT_REG, 0, OOT_REG, 0, 6, randomOffset(), 0);
        idleRows(2, 1'b0, 1);
        appendOp(2, 1'b0, OOT_REG, 6, OOT_REG, 0, 7, randomOffset(), 0);
        o = randomOffset();
        w = takeBits(32);
        appendOp(2, 1'b1, OOT_PC, 0, OOT_REG, 6, 0, o, w);
        appendOp(2, 1'b0, OOT_REG, 0, OOT_REG, 0, 8, w + o, 0);

        o = randomOffset();
        appendOp(3, 1'b1, OOT_REG, 9, OOT_PC, 0, 0, o, takeBits(32));
        attachAlloc(9);
        idleRows(3, 1'b0, 1);
        appendOp(3, 1'b0, OOT_REG, 0, OOT_REG, 0, 10, o, 0);
        // Reload r9 so its ready bit is set again
        appendOp(3, 1'b0, OOT_REG, 0, OOT_REG, 0, 9, randomOffset(), 0);

        o = randomOffset();
        appendOp(4, 1'b1, OOT_REG, 0, OOT_PC, 0, 0, o, takeBits(32));
        idleRows(4, 1'b0, 1);
        attachFlush(1'b1, 0, 0);
        appendOp(4, 1'b1, OOT_REG, 0, OOT_PC, 0, 0, o, takeBits(32));
        pinAlPtr(14);
        idleRows(4, 1'b0, 1);
        attachFlush(1'b0, 12, 2);
        appendOp(4, 1'b0, OOT_REG, 0, OOT_REG, 0, 11, o, 0);
        pinAlPtr(1);
        idleRows(4, 1'b0, 1);
        attachFlush(1'b0, 12, 2);
        appendOp(4, 1'b0, OOT_REG, 0, OOT_REG, 0, 11, o, 0);
        pinAlPtr(6);
        idleRows(4, 1'b0, 1);
        attachFlush(1'b0, 12, 2);

        o = randomOffset();
        appendOp(5, 1'b1, OOT_REG, 0, OOT_PC, 0, 0, o, takeBits(32));
        appendOp(5, 1'b0, OOT_REG, 0, OOT_REG, 0, 12, o, 0);
        idleRows(5, 1'b1, 5);

        for (int i = 0; i < 10; i++) begin
            st = takeBits(1);
            if (st) begin
                appendOp(6, 1'b1, OOT_REG, (i % 2) ? 5 : 0, OOT_PC, 0, 0, randomOffset(),
                         takeBits(32));
            end else begin
                appendOp(6, 1'b0, OOT_REG, (i % 2) ? 5 : 0, OOT_REG, 0, 16 + i,
                         randomOffset(), 0);
            end
        end
    endtask

    // Reference behaviour of one op leaving the register-read stage
    task automatic evalOp(input MemIssueEntry op, input FlushReq fl);
        ExpCompletion          e;
        logic [DATA_WIDTH-1:0] opA;
        logic [DATA_WIDTH-1:0] opB;
        logic [3:0]            idx;
        logic                  dropped;
        dropped = fl.valid &&
                  (fl.flushAll || inFlushRange(op.activeListPtr, fl.headPtr, fl.tailPtr));
        if (!dropped) begin
            opA = operandOf(op.operandTypeA, modelReg[op.phySrcRegNumA], op.imm, op.pc);
            opB = operandOf(op.operandTypeB, modelReg[op.phySrcRegNumB], '0, op.pc);
            e.replay = (op.operandTypeA == OOT_REG && !modelReady[op.phySrcRegNumA]) ||
                       (op.operandTypeB == OOT_REG && !modelReady[op.phySrcRegNumB]);
            e.isStore = op.isStore;
            e.checkData = !op.isStore && !e.replay;
            e.activeListPtr = op.activeListPtr;
            e.addr = opA + op.imm;
            // Execute register on this edge, result register on the next advance
            e.due = advanceCount + 2;
            idx = e.addr[5:2];
            e.loadData = modelMem[idx];
            if (op.isStore && !e.replay) begin
                modelMem[idx] = opB;
            end
            if (e.checkData && op.writeReg) begin
                modelReg[op.phyDstRegNum] = modelMem[idx];
                modelReady[op.phyDstRegNum] = 1'b1;
            end
            expQ.push_back(e);
        end
    endtask

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errorCount++;
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // A completion shows only in the cycle its op is due, never during a stall
    task automatic checkCompletion();
        ExpCompletion e;
        logic         expValid;
        expValid = (expQ.size() > 0) && (expQ[0].due == advanceCount);
        compareValue("completion.valid", completion.valid, expValid);
        if (expValid) begin
            e = expQ.pop_front();
            if (completion.valid === 1'b1) begin
                compareValue("completion.replay", completion.replay, e.replay);
                compareValue("completion.isStore", completion.isStore, e.isStore);
                compareValue("completion.activeListPtr", completion.activeListPtr,
                             e.activeListPtr);
                compareValue("completion.addr", completion.addr, e.addr);
                if (e.checkData) begin
                    compareValue("completion.loadData", completion.loadData, e.loadData);
                end
            end
        end
    endtask

    // Outputs are sampled before the new row is driven on the same falling edge
    task automatic applyRow(input StimRow row);
        @(negedge clk);
        checkCompletion();
        issue = row.issue;
        stall = row.stall;
        flush = row.flush;
        allocValid = row.allocValid;
        allocReg = row.allocReg;
        if (!row.stall && rrOp.valid) begin
            evalOp(rrOp, row.flush);
        end
        if (row.allocValid) begin
            modelReady[row.allocReg] = 1'b0;
        end
        if (!row.stall) begin
            rrOp = row.issue;
            advanceCount++;
        end
    endtask

    task automatic drainPipe();
        StimRow idle;
        int     cycles;
        idle = '0;
        cycles = 0;
        while ((expQ.size() > 0 || rrOp.valid) && cycles < DRAIN_LIMIT) begin
            applyRow(idle);
            cycles++;
        end
        checkCount++;
        assert (expQ.size() == 0) else begin
            errorCount++;
            $display("Error at %0t ns: %0d completions still missing after %0d cycles",
                     $time, expQ.size(), cycles);
            expQ.delete();
        end
    endtask

    initial begin
        StimRow idle;
        int     rowIdx;
        int     errBefore;
        rstN = 1'b0;
        issue = '0;
        stall = 1'b0;
        flush = '0;
        allocValid = 1'b0;
        allocReg = '0;
        advanceCount = 0;
        rrOp = '0;
        idle = '0;
        checkCount = 0;
        errorCount = 0;
        lfsrState = 32'h0d4728df;
        nextAlPtr = '0;
        for (int i = 0; i < PREG_NUM; i++) begin
            modelReg[i] = '0;
        end
        modelReady = '1;
        buildTable();

        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            compareValue("completion.valid", completion.valid, 1'b0);
        end
        rstN = 1'b1;

        rowIdx = 0;
        for (int t = 1; t <= 6; t++) begin
            errBefore = errorCount;
            while (rowIdx < stimTable.size() && stimTable[rowIdx].testId == t) begin
                applyRow(stimTable[rowIdx]);
                rowIdx++;
            end
            drainPipe();
            $display("Test %0d, %s: %s (%0d errors)", t, testName(t),
                     (errorCount == errBefore) ? "ok" : "failed", errorCount - errBefore);
        end
        // A few quiet cycles to catch stray completions
        for (int i = 0; i < 3; i++) begin
            applyRow(idle);
        end

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- design/memPipeTop.sv
/*
 * Top level of the memory pipeline slice
 * Register-read, execute and result stages around the register file
 */
`timescale 1ns/1ps

module memPipeTop import memPipePkg::*; (
    input  logic                      clk,
    input  logic                      rstN,
    input  MemIssueEntry              issue,
    input  logic                      stall,
    input  FlushReq                   flush,
    input  logic                      allocValid,
    input  logic [PREG_NUM_WIDTH-1:0] allocReg,
    output MemCompletion              completion
);

    logic [PREG_NUM_WIDTH-1:0] srcRegNumA;
    logic [PREG_NUM_WIDTH-1:0] srcRegNumB;
    PRegData                   srcDataA;
    PRegData                   srcDataB;
    MemExecEntry               rrToExec;
    MemResultEntry             execToResult;
    RegWrite                   loadWrite;

    physRegFile regFile (
        .clk(clk), .rstN(rstN),
        .readNumA(srcRegNumA), .readNumB(srcRegNumB),
        .readDataA(srcDataA), .readDataB(srcDataB),
        .regWrite(loadWrite), .allocValid(allocValid), .allocReg(allocReg)
    );

    memRegReadStage regReadStage (
        .clk(clk), .rstN(rstN), .stall(stall), .issue(issue), .flush(flush),
        .srcRegNumA(srcRegNumA), .srcRegNumB(srcRegNumB),
        .srcDataA(srcDataA), .srcDataB(srcDataB), .nextStage(rrToExec)
    );

    memExecStage execStage (
        .clk(clk), .rstN(rstN), .stall(stall),
        .prev(rrToExec), .nextStage(execToResult)
    );

    memResultStage resultStage (
        .clk(clk), .rstN(rstN), .stall(stall), .prev(execToResult),
        .regWrite(loadWrite), .completion(completion)
    );

endmodule

//--- design/memResultStage.sv
/*
 * Result stage of the memory pipe
 * 16-word data memory, load write-back and completion record
 */
`timescale 1ns/1ps

module memResultStage import memPipePkg::*; (
    input  logic          clk,
    input  logic          rstN,
    input  logic          stall,
    input  MemResultEntry prev,
    output RegWrite       regWrite,
    output MemCompletion  completion
);

    MemResultEntry pipeReg;
    logic [DATA_WIDTH-1:0] loadDataReg;
    logic [DATA_WIDTH-1:0] dataMem [DMEM_WORDS];
    logic [DMEM_INDEX_WIDTH-1:0] wordIdx;
    logic memWrite;

    assign wordIdx = prev.addr[DMEM_INDEX_LSB +: DMEM_INDEX_WIDTH];

    // Replayed stores leave memory untouched
    assign memWrite = prev.valid && prev.isStore && !prev.replay && !stall;

    always_ff @(posedge clk) begin
        if (memWrite) begin
            dataMem[wordIdx] <= prev.storeData;
        end
    end

    // Load data is read in the execute cycle and kept with its entry
    always_ff @(posedge clk) begin
        if (!stall) begin
            loadDataReg <= dataMem[wordIdx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pipeReg.valid <= 1'b0;
        end else if (!stall) begin
            pipeReg <= prev;
        end
    end

    always_comb begin
        completion.valid         = pipeReg.valid && !stall;
        completion.replay        = pipeReg.replay;
        completion.isStore       = pipeReg.isStore;
        completion.activeListPtr = pipeReg.activeListPtr;
        completion.addr          = pipeReg.addr;
        completion.loadData      = loadDataReg;
    end

    always_comb begin
        regWrite.valid  = pipeReg.valid && !stall && !pipeReg.replay &&
                          !pipeReg.isStore && pipeReg.writeReg;
        regWrite.regNum = pipeReg.phyDstRegNum;
        regWrite.data   = loadDataReg;
    end

endmodule

//--- design/memExecStage.sv
/*
 * Execute stage of the memory pipe
 * Address generation from base plus offset
 */
`timescale 1ns/1ps

module memExecStage import memPipePkg::*; (
    input  logic          clk,
    input  logic          rstN,
    input  logic          stall,
    input  MemExecEntry   prev,
    output MemResultEntry nextStage
);

    MemExecEntry pipeReg;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pipeReg.valid <= 1'b0;
        end else if (!stall) begin
            pipeReg <= prev;
        end
    end

    always_comb begin
        // Frozen entry must not reach the result stage twice
        nextStage.valid         = pipeReg.valid && !stall;
        nextStage.replay        = pipeReg.replay;
        nextStage.isStore       = pipeReg.isStore;
        nextStage.writeReg      = pipeReg.writeReg;
        nextStage.phyDstRegNum  = pipeReg.phyDstRegNum;
        nextStage.activeListPtr = pipeReg.activeListPtr;

        // Base plus offset
        nextStage.addr      = pipeReg.operandA + pipeReg.imm;
        nextStage.storeData = pipeReg.operandB;
    end

endmodule

//--- design/memRegReadStage.sv
/*
 * Register-read stage of the memory pipe
 * Operand decode and select, selective flush check, replay on unready source
 */
`timescale 1ns/1ps

module memRegReadStage import memPipePkg::*; (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      stall,
    input  MemIssueEntry              issue,
    input  FlushReq                   flush,
    output logic [PREG_NUM_WIDTH-1:0] srcRegNumA,
    output logic [PREG_NUM_WIDTH-1:0] srcRegNumB,
    input  PRegData                   srcDataA,
    input  PRegData                   srcDataB,
    output MemExecEntry               nextStage
);

    MemIssueEntry pipeReg;
    logic         flushHit;
    logic         inRange;
    logic         notReadyA;
    logic         notReadyB;

    function automatic logic [DATA_WIDTH-1:0] selectOperand(
        input OpOperandType          opType,
        input logic [DATA_WIDTH-1:0] regVal,
        input logic [DATA_WIDTH-1:0] immVal,
        input logic [DATA_WIDTH-1:0] pcVal
    );
        logic [DATA_WIDTH-1:0] result;
        case (opType)
            OOT_IMM: result = immVal;
            OOT_PC:  result = pcVal;
            default: result = regVal;
        endcase
        return result;
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pipeReg.valid <= 1'b0;
        end else if (!stall) begin
            pipeReg <= issue;
        end else if (flushHit) begin
            // Held op is killed even while the pipe is frozen
            pipeReg.valid <= 1'b0;
        end
    end

    // Head-to-tail range may wrap past the end of the active list
    always_comb begin
        if (flush.headPtr <= flush.tailPtr) begin
            inRange = (pipeReg.activeListPtr >= flush.headPtr) &&
                      (pipeReg.activeListPtr < flush.tailPtr);
        end else begin
            inRange = (pipeReg.activeListPtr >= flush.headPtr) ||
                      (pipeReg.activeListPtr < flush.tailPtr);
        end
        flushHit = flush.valid && (flush.flushAll || inRange);
    end

    assign srcRegNumA = pipeReg.phySrcRegNumA;
    assign srcRegNumB = pipeReg.phySrcRegNumB;

    always_comb begin
        notReadyA = (pipeReg.operandTypeA == OOT_REG) && !srcDataA.ready;
        notReadyB = (pipeReg.operandTypeB == OOT_REG) && !srcDataB.ready;

        nextStage.valid         = pipeReg.valid && !stall && !flushHit;
        nextStage.replay        = notReadyA || notReadyB;
        nextStage.isStore       = pipeReg.isStore;
        nextStage.writeReg      = pipeReg.writeReg;
        nextStage.phyDstRegNum  = pipeReg.phyDstRegNum;
        nextStage.imm           = pipeReg.imm;
        nextStage.activeListPtr = pipeReg.activeListPtr;

        // Base may come from a register, the immediate or the PC
        nextStage.operandA = selectOperand(pipeReg.operandTypeA, srcDataA.data,
                                           pipeReg.imm, pipeReg.pc);
        // Imm is the address offset, so store data never takes it
        nextStage.operandB = selectOperand(pipeReg.operandTypeB, srcDataB.data,
                                           '0, pipeReg.pc);
    end

endmodule

//--- design/physRegFile.sv
/*
 * Physical register file with one ready bit per register
 * Two combinational read ports with write-through of the load result
 */
`timescale 1ns/1ps

module physRegFile import memPipePkg::*; (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [PREG_NUM_WIDTH-1:0] readNumA,
    input  logic [PREG_NUM_WIDTH-1:0] readNumB,
    output PRegData                   readDataA,
    output PRegData                   readDataB,
    input  RegWrite                   regWrite,
    input  logic                      allocValid,
    input  logic [PREG_NUM_WIDTH-1:0] allocReg
);

    logic [DATA_WIDTH-1:0] regData [PREG_NUM];
    logic [PREG_NUM-1:0]   regReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < PREG_NUM; i++) begin
                regData[i] <= '0;
            end
            regReady <= '1;
        end else begin
            if (allocValid) begin
                regReady[allocReg] <= 1'b0;
            end
            // Placed after the allocation so the write wins on a clash
            if (regWrite.valid) begin
                regData[regWrite.regNum]  <= regWrite.data;
                regReady[regWrite.regNum] <= 1'b1;
            end
        end
    end

    // Same-cycle write shows up on the read ports
    always_comb begin
        readDataA.data  = regData[readNumA];
        readDataA.ready = regReady[readNumA];
        if (regWrite.valid && regWrite.regNum == readNumA) begin
            readDataA.data  = regWrite.data;
            readDataA.ready = 1'b1;
        end
        readDataB.data  = regData[readNumB];
        readDataB.ready = regReady[readNumB];
        if (regWrite.valid && regWrite.regNum == readNumB) begin
            readDataB.data  = regWrite.data;
            readDataB.ready = 1'b1;
        end
    end

endmodule

//--- design/memPipePkg.sv
/*
 * Widths and sizes of the memory pipeline slice
 * Operand-type encoding
 * Structs passed between the stages, the register file and the top level
 */
package memPipePkg;

    localparam int DATA_WIDTH = 32;
    localparam int PREG_NUM_WIDTH = 5;
    localparam int PREG_NUM = 1 << PREG_NUM_WIDTH;
    localparam int AL_PTR_WIDTH = 4;
    localparam int DMEM_WORDS = 16;
    localparam int DMEM_INDEX_WIDTH = $clog2(DMEM_WORDS);
    // Word index sits just above the byte offset
    localparam int DMEM_INDEX_LSB = 2;

    typedef enum logic [1:0] {
        OOT_REG = 2'b00,
        OOT_IMM = 2'b01,
        OOT_PC  = 2'b10
    } OpOperandType;

    // Op as it leaves the issue queue
    typedef struct packed {
        logic                      valid;
        logic                      isStore;
        OpOperandType              operandTypeA;
        OpOperandType              operandTypeB;
        logic [PREG_NUM_WIDTH-1:0] phySrcRegNumA;
        logic [PREG_NUM_WIDTH-1:0] phySrcRegNumB;
        logic                      writeReg;
        logic [PREG_NUM_WIDTH-1:0] phyDstRegNum;
        logic [DATA_WIDTH-1:0]     imm;
        logic [DATA_WIDTH-1:0]     pc;
        logic [AL_PTR_WIDTH-1:0]   activeListPtr;
    } MemIssueEntry;

    // Range is head up to tail, exclusive, modulo the active-list size
    typedef struct packed {
        logic                    valid;
        logic                    flushAll;
        logic [AL_PTR_WIDTH-1:0] headPtr;
        logic [AL_PTR_WIDTH-1:0] tailPtr;
    } FlushReq;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  ready;
    } PRegData;

    typedef struct packed {
        logic                      valid;
        logic                      replay;
        logic                      isStore;
        logic                      writeReg;
        logic [PREG_NUM_WIDTH-1:0] phyDstRegNum;
        logic [DATA_WIDTH-1:0]     imm;
        logic [AL_PTR_WIDTH-1:0]   activeListPtr;
        logic [DATA_WIDTH-1:0]     operandA;
        logic [DATA_WIDTH-1:0]     operandB;
    } MemExecEntry;

    typedef struct packed {
        logic                      valid;
        logic                      replay;
        logic                      isStore;
        logic                      writeReg;
        logic [PREG_NUM_WIDTH-1:0] phyDstRegNum;
        logic [DATA_WIDTH-1:0]     addr;
        logic [DATA_WIDTH-1:0]     storeData;
        logic [AL_PTR_WIDTH-1:0]   activeListPtr;
    } MemResultEntry;

    typedef struct packed {
        logic                    valid;
        logic                    replay;
        logic                    isStore;
        logic [AL_PTR_WIDTH-1:0] activeListPtr;
        logic [DATA_WIDTH-1:0]   addr;
        logic [DATA_WIDTH-1:0]   loadData;
    } MemCompletion;

    typedef struct packed {
        logic                      valid;
        logic [PREG_NUM_WIDTH-1:0] regNum;
        logic [DATA_WIDTH-1:0]     data;
    } RegWrite;

endpackage
